// ==== build.f ====
design/aib_cal_pkg.sv
design/aib_bit_sync.sv
design/aib_osc_seq.sv
design/aib_rx_cal_seq.sv
design/aib_tx_cal_seq.sv
design/aib_cal_top.sv
sim/tb_aib_cal.sv

// ==== Makefile ====
.PHONY: sim clean

sim:
	verilator --binary --timing --assert --timescale 1ns/1ps -f build.f \
		--top-module tb_aib_cal -Mdir obj_dir -o sim_aib_cal
	./obj_dir/sim_aib_cal | tee sim.log
	grep -q "^Testbench passed$$" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== sim/tb_aib_cal.sv ====
`timescale 1ns/1ps

module tb_aib_cal;

    import aib_cal_pkg::*;

    localparam int CLK_PERIOD  = 20;
    localparam int HOLD_CYCLES = 10;
    localparam int TOTAL_STEPS = 82;
    localparam int WATCHDOG_NS = TOTAL_STEPS * HOLD_CYCLES * CLK_PERIOD * 2;

    logic                   osc_clk;
    logic                   ms_reset_n_sync;
    logic [SYNC_W-1:0]      stim;                  // Same bit order as the sync vector

    logic                   o_osc_transfer_en;
    logic                   o_osc_transfer_alive;
    logic                   o_rx_async_rst;
    logic                   o_rx_dll_lock_req;
    logic                   o_rx_dll_lock;
    logic                   o_rx_transfer_en;
    logic                   o_tx_async_rst;
    logic                   o_tx_dcc_cal_req;
    logic                   o_tx_dcc_cal_done;
    logic                   o_tx_transfer_en;

    logic [OSC_STATE_W-1:0] model_osc;
    logic [CAL_STATE_W-1:0] model_rx;
    logic [CAL_STATE_W-1:0] model_tx;
    logic [9:0]             expected;
    logic [9:0]             actual;
    int                     req_count  = 0;
    int                     done_count = 0;
    int                     pass_count = 0;
    int                     fail_count = 0;
    int                     step_count = 0;
    integer                 seed;

    aib_cal_top i_dut (
        .osc_clk               (osc_clk),
        .ms_reset_n_sync       (ms_reset_n_sync),
        .i_config_done         (stim[SYNC_CONFIG_DONE]),
        .i_rem_osc_transfer_en (stim[SYNC_REM_OSC_EN]),
        .i_rem_tx_lock_req     (stim[SYNC_REM_TX_REQ]),
        .i_loc_rx_lock_req     (stim[SYNC_LOC_RX_REQ]),
        .i_loc_rx_dll_lock     (stim[SYNC_LOC_RX_LOCK]),
        .i_rem_tx_cal_done     (stim[SYNC_REM_TX_CAL_DONE]),
        .i_rem_rx_lock_req     (stim[SYNC_REM_RX_REQ]),
        .i_loc_tx_lock_req     (stim[SYNC_LOC_TX_REQ]),
        .i_loc_tx_cal_done     (stim[SYNC_LOC_TX_CAL_DONE]),
        .i_rem_rx_dll_lock     (stim[SYNC_REM_RX_LOCK]),
        .i_rem_rx_transfer_en  (stim[SYNC_REM_RX_XFER_EN]),
        .o_osc_transfer_en     (o_osc_transfer_en),
        .o_osc_transfer_alive  (o_osc_transfer_alive),
        .o_rx_async_rst        (o_rx_async_rst),
        .o_rx_dll_lock_req     (o_rx_dll_lock_req),
        .o_rx_dll_lock         (o_rx_dll_lock),
        .o_rx_transfer_en      (o_rx_transfer_en),
        .o_tx_async_rst        (o_tx_async_rst),
        .o_tx_dcc_cal_req      (o_tx_dcc_cal_req),
        .o_tx_dcc_cal_done     (o_tx_dcc_cal_done),
        .o_tx_transfer_en      (o_tx_transfer_en)
    );

    initial begin
        osc_clk = 1'b0;
        forever #(CLK_PERIOD / 2) osc_clk = ~osc_clk;
    end

    // ========================================
    // Reference model
    // ========================================
    function automatic logic [OSC_STATE_W-1:0] osc_step(input logic [OSC_STATE_W-1:0] s,
                                                         input logic cfg, input logic rem_en);
        logic [OSC_STATE_W-1:0] n;
        n = s;
        if (!cfg) begin
            n = OSC_WAIT;
        end else if (s == OSC_WAIT) begin
            n = OSC_XFER_EN;
        end else if (s == OSC_XFER_EN && rem_en) begin
            n = OSC_ALIVE;
        end
        return n;
    endfunction

    function automatic logic [CAL_STATE_W-1:0] rx_step(input logic [CAL_STATE_W-1:0] s,
        input logic alive, input logic reqs, input logic cal_done, input logic lock);
        logic [CAL_STATE_W-1:0] n;
        n = s;
        if (s != RXC_WAIT && !reqs) begin
            n = RXC_WAIT;                              // Abort on lost request
        end else if (s == RXC_WAIT && alive && reqs) begin
            n = RXC_WAIT_REM_CAL;
        end else if (s == RXC_WAIT_REM_CAL && cal_done) begin
            n = RXC_LOCK_REQ;
        end else if (s == RXC_LOCK_REQ && lock) begin
            n = RXC_LOCKED;
        end else if (s == RXC_LOCKED) begin
            n = RXC_XFER_EN;
        end
        return n;
    endfunction

    function automatic logic [CAL_STATE_W-1:0] tx_step(input logic [CAL_STATE_W-1:0] s,
        input logic alive, input logic reqs, input logic cal_done, input logic rem_lock,
        input logic rem_xfer);
        logic [CAL_STATE_W-1:0] n;
        n = s;
        if (s != TXC_WAIT && !reqs) begin
            n = TXC_WAIT;
        end else if (s == TXC_WAIT && alive && reqs) begin
            n = TXC_CAL_REQ;
        end else if (s == TXC_CAL_REQ && cal_done) begin
            n = TXC_WAIT_REM_LOCK;
        end else if (s == TXC_WAIT_REM_LOCK && rem_lock) begin
            n = TXC_WAIT_REM_XFER;
        end else if (s == TXC_WAIT_REM_XFER && rem_xfer) begin
            n = TXC_XFER_EN;
        end
        return n;
    endfunction

    function automatic void predict(
        input  logic [OSC_STATE_W-1:0] osc_s,
        input  logic [CAL_STATE_W-1:0] rx_s,
        input  logic [CAL_STATE_W-1:0] tx_s,
        input  logic [SYNC_W-1:0]      lv,
        output logic [OSC_STATE_W-1:0] osc_n,
        output logic [CAL_STATE_W-1:0] rx_n,
        output logic [CAL_STATE_W-1:0] tx_n,
        output logic [9:0]             outs
    );
        logic                   alive;
        logic                   rx_reqs;
        logic                   tx_reqs;
        logic                   changed;
        logic [OSC_STATE_W-1:0] osc_p;
        logic [CAL_STATE_W-1:0] rx_p;
        logic [CAL_STATE_W-1:0] tx_p;
        rx_reqs = lv[SYNC_REM_TX_REQ] & lv[SYNC_LOC_RX_REQ];
        tx_reqs = lv[SYNC_REM_RX_REQ] & lv[SYNC_LOC_TX_REQ];
        osc_n   = osc_s;
        rx_n    = rx_s;
        tx_n    = tx_s;
        // Calibration FSMs see the old alive level for a few cycles, then the new one
        for (int phase = 0; phase < 2; phase++) begin
            alive   = (phase == 0) ? (osc_s == OSC_ALIVE) : (osc_n == OSC_ALIVE);
            changed = 1'b1;
            while (changed) begin
                osc_p = osc_n;
                rx_p  = rx_n;
                tx_p  = tx_n;
                osc_n = osc_step(osc_n, lv[SYNC_CONFIG_DONE], lv[SYNC_REM_OSC_EN]);
                rx_n  = rx_step(rx_n, alive, rx_reqs, lv[SYNC_REM_TX_CAL_DONE],
                                lv[SYNC_LOC_RX_LOCK]);
                tx_n  = tx_step(tx_n, alive, tx_reqs, lv[SYNC_LOC_TX_CAL_DONE],
                                lv[SYNC_REM_RX_LOCK], lv[SYNC_REM_RX_XFER_EN]);
                changed = (osc_p != osc_n) || (rx_p != rx_n) || (tx_p != tx_n);
            end
        end
        outs[9] = (osc_n != OSC_WAIT);
        outs[8] = (osc_n == OSC_ALIVE);
        outs[7] = (rx_n != RXC_WAIT);
        outs[6] = (rx_n >= RXC_LOCK_REQ);
        outs[5] = (rx_n >= RXC_LOCKED);
        outs[4] = (rx_n == RXC_XFER_EN);
        outs[3] = (tx_n != TXC_WAIT);
        outs[2] = (tx_n >= TXC_CAL_REQ);
        outs[1] = (tx_n >= TXC_WAIT_REM_LOCK);
        outs[0] = (tx_n == TXC_XFER_EN);
    endfunction

    function automatic string out_name(input int idx);
        case (idx)
            9:       return "o_osc_transfer_en";
            8:       return "o_osc_transfer_alive";
            7:       return "o_rx_async_rst";
            6:       return "o_rx_dll_lock_req";
            5:       return "o_rx_dll_lock";
            4:       return "o_rx_transfer_en";
            3:       return "o_tx_async_rst";
            2:       return "o_tx_dcc_cal_req";
            1:       return "o_tx_dcc_cal_done";
            default: return "o_tx_transfer_en";
        endcase
    endfunction

    // ========================================
    // Output comparison
    // ========================================
    always @(negedge osc_clk) begin
        if (done_count != req_count) begin
            actual = {o_osc_transfer_en, o_osc_transfer_alive,
                      o_rx_async_rst, o_rx_dll_lock_req, o_rx_dll_lock, o_rx_transfer_en,
                      o_tx_async_rst, o_tx_dcc_cal_req, o_tx_dcc_cal_done, o_tx_transfer_en};
            if (actual === expected) begin
                pass_count++;
            end else begin
                fail_count++;
                for (int i = 9; i >= 0; i--) begin
                    if (actual[i] !== expected[i]) begin
                        $display("Fail at %0t ns: %s expected %b, got %b",
                                 $time, out_name(i), expected[i], actual[i]);
                    end
                end
            end
            done_count++;
        end
    end

    // ========================================
    // Stimulus tasks
    // ========================================
    task automatic apply_step(input logic [SYNC_W-1:0] next_stim);
        logic [OSC_STATE_W-1:0] osc_n;
        logic [CAL_STATE_W-1:0] rx_n;
        logic [CAL_STATE_W-1:0] tx_n;
        logic [9:0]             outs;
        @(posedge osc_clk);
        #2;
        stim = next_stim;
        predict(model_osc, model_rx, model_tx, next_stim, osc_n, rx_n, tx_n, outs);
        model_osc = osc_n;
        model_rx  = rx_n;
        model_tx  = tx_n;
        expected  = outs;
        repeat (HOLD_CYCLES) @(posedge osc_clk);   // Covers sync, FSM and output latency
        req_count++;
        wait (done_count == req_count);
        step_count++;
    endtask

    task automatic change_input(input int idx, input logic val);
        logic [SYNC_W-1:0] s;
        s      = stim;
        s[idx] = val;
        apply_step(s);
    endtask

    task automatic random_step(input logic cfg_low);
        logic [31:0]       r1;
        logic [31:0]       r2;
        logic [SYNC_W-1:0] s;
        r1 = $random(seed);
        r2 = $random(seed);
        s  = r1[SYNC_W-1:0] | r2[SYNC_W-1:0];      // Each level high three times in four
        if (cfg_low) begin
            s[SYNC_CONFIG_DONE] = 1'b0;
        end
        apply_step(s);
    endtask

    task automatic report_test(input string name, input int fails_at, input int steps_at);
        $display("Test %s done: %0d steps, %0d mismatches",
                 name, step_count - steps_at, fail_count - fails_at);
    endtask

    // ========================================
    // Test sequence
    // ========================================
    initial begin
        int f0;
        int s0;
        seed            = 32'ha3bc925b;
        stim            = '0;
        ms_reset_n_sync = 1'b0;
        model_osc       = OSC_WAIT;
        model_rx        = RXC_WAIT;
        model_tx        = TXC_WAIT;
        expected        = '0;
        repeat (4) @(posedge osc_clk);
        #2;
        ms_reset_n_sync = 1'b1;

        f0 = fail_count;
        s0 = step_count;
        apply_step('0);
        repeat (5) random_step(1'b1);
        report_test("1 reset and config low", f0, s0);

        f0 = fail_count;
        s0 = step_count;
        apply_step('0);
        change_input(SYNC_CONFIG_DONE, 1'b1);
        change_input(SYNC_REM_OSC_EN, 1'b1);
        change_input(SYNC_CONFIG_DONE, 1'b0);
        report_test("2 oscillator hand-off", f0, s0);

        f0 = fail_count;
        s0 = step_count;
        change_input(SYNC_CONFIG_DONE, 1'b1);      // Alive again
        change_input(SYNC_REM_TX_REQ, 1'b1);
        change_input(SYNC_LOC_RX_REQ, 1'b1);
        change_input(SYNC_REM_TX_CAL_DONE, 1'b1);
        change_input(SYNC_LOC_RX_LOCK, 1'b1);
        report_test("3 rx calibration", f0, s0);

        f0 = fail_count;
        s0 = step_count;
        change_input(SYNC_REM_RX_REQ, 1'b1);
        change_input(SYNC_LOC_TX_REQ, 1'b1);
        change_input(SYNC_LOC_TX_CAL_DONE, 1'b1);
        change_input(SYNC_REM_RX_LOCK, 1'b1);
        change_input(SYNC_REM_RX_XFER_EN, 1'b1);
        report_test("4 tx calibration", f0, s0);

        f0 = fail_count;
        s0 = step_count;
        change_input(SYNC_LOC_RX_REQ, 1'b0);
        change_input(SYNC_REM_RX_REQ, 1'b0);
        report_test("5 request drop", f0, s0);

        f0 = fail_count;
        s0 = step_count;
        repeat (60) random_step(1'b0);
        report_test("6 random levels", f0, s0);

        $display("Checks: %0d passed, %0d failed", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: the run did not finish within %0d ns", WATCHDOG_NS);
        $display("Testbench failed");
        $finish;
    end

endmodule

// ==== design/aib_cal_top.sv ====
`timescale 1ns/1ps

module aib_cal_top (
    input  logic osc_clk,
    input  logic ms_reset_n_sync,
    input  logic i_config_done,
    input  logic i_rem_osc_transfer_en,
    input  logic i_rem_tx_lock_req,
    input  logic i_loc_rx_lock_req,
    input  logic i_loc_rx_dll_lock,
    input  logic i_rem_tx_cal_done,
    input  logic i_rem_rx_lock_req,
    input  logic i_loc_tx_lock_req,
    input  logic i_loc_tx_cal_done,
    input  logic i_rem_rx_dll_lock,
    input  logic i_rem_rx_transfer_en,
    output logic o_osc_transfer_en,
    output logic o_osc_transfer_alive,
    output logic o_rx_async_rst,
    output logic o_rx_dll_lock_req,
    output logic o_rx_dll_lock,
    output logic o_rx_transfer_en,
    output logic o_tx_async_rst,
    output logic o_tx_dcc_cal_req,
    output logic o_tx_dcc_cal_done,
    output logic o_tx_transfer_en
);

    import aib_cal_pkg::*;

    logic [SYNC_W-1:0] status_async;
    logic [SYNC_W-1:0] status_sync;

    // ========================================
    // Status synchronizers
    // ========================================
    assign status_async = {i_rem_rx_transfer_en,   // SYNC_REM_RX_XFER_EN
                           i_rem_rx_dll_lock,
                           i_loc_tx_cal_done,
                           i_loc_tx_lock_req,
                           i_rem_rx_lock_req,
                           i_rem_tx_cal_done,
                           i_loc_rx_dll_lock,
                           i_loc_rx_lock_req,
                           i_rem_tx_lock_req,
                           i_rem_osc_transfer_en,
                           i_config_done};         // SYNC_CONFIG_DONE

    aib_bit_sync u_bit_sync (
        .osc_clk         (osc_clk),
        .ms_reset_n_sync (ms_reset_n_sync),
        .i_async         (status_async),
        .o_sync          (status_sync)
    );

    // ========================================
    // Sequencers
    // ========================================
    aib_osc_seq u_osc_seq (
        .osc_clk               (osc_clk),
        .ms_reset_n_sync       (ms_reset_n_sync),
        .i_config_done         (status_sync[SYNC_CONFIG_DONE]),
        .i_rem_osc_transfer_en (status_sync[SYNC_REM_OSC_EN]),
        .o_osc_transfer_en     (o_osc_transfer_en),
        .o_osc_transfer_alive  (o_osc_transfer_alive)
    );

    aib_rx_cal_seq u_rx_cal_seq (
        .osc_clk           (osc_clk),
        .ms_reset_n_sync   (ms_reset_n_sync),
        .i_osc_alive       (o_osc_transfer_alive),
        .i_rem_tx_req      (status_sync[SYNC_REM_TX_REQ]),
        .i_loc_rx_req      (status_sync[SYNC_LOC_RX_REQ]),
        .i_rem_tx_cal_done (status_sync[SYNC_REM_TX_CAL_DONE]),
        .i_loc_rx_dll_lock (status_sync[SYNC_LOC_RX_LOCK]),
        .o_rx_async_rst    (o_rx_async_rst),
        .o_rx_dll_lock_req (o_rx_dll_lock_req),
        .o_rx_dll_lock     (o_rx_dll_lock),
        .o_rx_transfer_en  (o_rx_transfer_en)
    );

    aib_tx_cal_seq u_tx_cal_seq (
        .osc_clk              (osc_clk),
        .ms_reset_n_sync      (ms_reset_n_sync),
        .i_osc_alive          (o_osc_transfer_alive),
        .i_rem_rx_req         (status_sync[SYNC_REM_RX_REQ]),
        .i_loc_tx_req         (status_sync[SYNC_LOC_TX_REQ]),
        .i_loc_tx_cal_done    (status_sync[SYNC_LOC_TX_CAL_DONE]),
        .i_rem_rx_dll_lock    (status_sync[SYNC_REM_RX_LOCK]),
        .i_rem_rx_transfer_en (status_sync[SYNC_REM_RX_XFER_EN]),
        .o_tx_async_rst       (o_tx_async_rst),
        .o_tx_dcc_cal_req     (o_tx_dcc_cal_req),
        .o_tx_dcc_cal_done    (o_tx_dcc_cal_done),
        .o_tx_transfer_en     (o_tx_transfer_en)
    );

endmodule

// ==== design/aib_tx_cal_seq.sv ====
`timescale 1ns/1ps

module aib_tx_cal_seq (
    input  logic osc_clk,
    input  logic ms_reset_n_sync,
    input  logic i_osc_alive,
    input  logic i_rem_rx_req,
    input  logic i_loc_tx_req,
    input  logic i_loc_tx_cal_done,
    input  logic i_rem_rx_dll_lock,
    input  logic i_rem_rx_transfer_en,
    output logic o_tx_async_rst,
    output logic o_tx_dcc_cal_req,
    output logic o_tx_dcc_cal_done,
    output logic o_tx_transfer_en
);

    import aib_cal_pkg::*;

    logic [CAL_STATE_W-1:0] state_q;
    logic [CAL_STATE_W-1:0] state_d;
    logic                   req_both;

    assign req_both = i_rem_rx_req & i_loc_tx_req;

    // ========================================
    // Next state
    // ========================================
    always_comb begin
        state_d = state_q;
        case (state_q)
            TXC_WAIT: begin
                if (i_osc_alive && req_both) begin
                    state_d = TXC_CAL_REQ;
                end
            end
            TXC_CAL_REQ: begin
                if (i_loc_tx_cal_done) begin
                    state_d = TXC_WAIT_REM_LOCK;           // Local DCC finished
                end
            end
            TXC_WAIT_REM_LOCK: begin
                if (i_rem_rx_dll_lock) begin
                    state_d = TXC_WAIT_REM_XFER;
                end
            end
            TXC_WAIT_REM_XFER: begin
                if (i_rem_rx_transfer_en) begin
                    state_d = TXC_XFER_EN;                 // Remote RX is open
                end
            end
            TXC_XFER_EN: begin
                state_d = TXC_XFER_EN;
            end
            default: begin
                state_d = TXC_WAIT;
            end
        endcase

        if (state_q != TXC_WAIT && !req_both) begin
            state_d = TXC_WAIT;                            // Request lost
        end
    end

    // ========================================
    // State and output flops
    // ========================================
    always_ff @(posedge osc_clk or negedge ms_reset_n_sync) begin
        if (!ms_reset_n_sync) begin
            state_q           <= TXC_WAIT;
            o_tx_async_rst    <= 1'b0;
            o_tx_dcc_cal_req  <= 1'b0;
            o_tx_dcc_cal_done <= 1'b0;
            o_tx_transfer_en  <= 1'b0;
        end else begin
            state_q           <= state_d;
            o_tx_async_rst    <= (state_q != TXC_WAIT);
            o_tx_dcc_cal_req  <= state_q inside {TXC_CAL_REQ, TXC_WAIT_REM_LOCK,
                                                 TXC_WAIT_REM_XFER, TXC_XFER_EN};
            o_tx_dcc_cal_done <= state_q inside {TXC_WAIT_REM_LOCK, TXC_WAIT_REM_XFER,
                                                 TXC_XFER_EN};
            o_tx_transfer_en  <= (state_q == TXC_XFER_EN);
        end
    end

    // Transfer enable only rises after a cycle of done
    a_xfer_after_done: assert property (
        @(posedge osc_clk) disable iff (!ms_reset_n_sync)
        $rose(o_tx_transfer_en) |-> $past(o_tx_dcc_cal_done) && o_tx_dcc_cal_done
    );

    // Done follows at least one cycle of request
    a_done_after_req: assert property (
        @(posedge osc_clk) disable iff (!ms_reset_n_sync)
        $rose(o_tx_dcc_cal_done) |-> $past(o_tx_dcc_cal_req) && o_tx_dcc_cal_req
    );

endmodule

// ==== design/aib_rx_cal_seq.sv ====
`timescale 1ns/1ps

module aib_rx_cal_seq (
    input  logic osc_clk,
    input  logic ms_reset_n_sync,
    input  logic i_osc_alive,
    input  logic i_rem_tx_req,
    input  logic i_loc_rx_req,
    input  logic i_rem_tx_cal_done,
    input  logic i_loc_rx_dll_lock,
    output logic o_rx_async_rst,
    output logic o_rx_dll_lock_req,
    output logic o_rx_dll_lock,
    output logic o_rx_transfer_en
);

    import aib_cal_pkg::*;

    logic [CAL_STATE_W-1:0] state_q;
    logic [CAL_STATE_W-1:0] state_d;
    logic                   req_both;

    assign req_both = i_rem_tx_req & i_loc_rx_req;         // Both ends want the link

    // ========================================
    // Next state
    // ========================================
    always_comb begin
        state_d = state_q;
        case (state_q)
            RXC_WAIT: begin
                if (i_osc_alive && req_both) begin
                    state_d = RXC_WAIT_REM_CAL;
                end
            end
            RXC_WAIT_REM_CAL: begin
                if (i_rem_tx_cal_done) begin
                    state_d = RXC_LOCK_REQ;                // Remote DCC finished
                end
            end
            RXC_LOCK_REQ: begin
                if (i_loc_rx_dll_lock) begin
                    state_d = RXC_LOCKED;
                end
            end
            RXC_LOCKED: begin
                state_d = RXC_XFER_EN;
            end
            RXC_XFER_EN: begin
                state_d = RXC_XFER_EN;
            end
            default: begin
                state_d = RXC_WAIT;
            end
        endcase

        // A dropped request aborts the sequence from any active state
        if (state_q != RXC_WAIT && !req_both) begin
            state_d = RXC_WAIT;
        end
    end

    // ========================================
    // State and output flops
    // ========================================
    always_ff @(posedge osc_clk or negedge ms_reset_n_sync) begin
        if (!ms_reset_n_sync) begin
            state_q           <= RXC_WAIT;
            o_rx_async_rst    <= 1'b0;
            o_rx_dll_lock_req <= 1'b0;
            o_rx_dll_lock     <= 1'b0;
            o_rx_transfer_en  <= 1'b0;
        end else begin
            state_q           <= state_d;
            o_rx_async_rst    <= (state_q != RXC_WAIT);    // Release of RX reset
            o_rx_dll_lock_req <= state_q inside {RXC_LOCK_REQ, RXC_LOCKED, RXC_XFER_EN};
            o_rx_dll_lock     <= state_q inside {RXC_LOCKED, RXC_XFER_EN};
            o_rx_transfer_en  <= (state_q == RXC_XFER_EN);
        end
    end

    // Lock only rises after a cycle of lock request
    a_lock_after_req: assert property (
        @(posedge osc_clk) disable iff (!ms_reset_n_sync)
        $rose(o_rx_dll_lock) |-> $past(o_rx_dll_lock_req) && o_rx_dll_lock_req
    );

    // Lock must already be up the cycle before transfer enable rises
    a_xfer_after_lock: assert property (
        @(posedge osc_clk) disable iff (!ms_reset_n_sync)
        $rose(o_rx_transfer_en) |-> $past(o_rx_dll_lock) && o_rx_dll_lock
    );

endmodule

// ==== design/aib_osc_seq.sv ====
`timescale 1ns/1ps

module aib_osc_seq (
    input  logic osc_clk,
    input  logic ms_reset_n_sync,
    input  logic i_config_done,
    input  logic i_rem_osc_transfer_en,
    output logic o_osc_transfer_en,
    output logic o_osc_transfer_alive
);

    import aib_cal_pkg::*;

    logic [OSC_STATE_W-1:0] state_q;
    logic [OSC_STATE_W-1:0] state_d;

    // ========================================
    // Next state
    // ========================================
    always_comb begin
        state_d = state_q;
        case (state_q)
            OSC_WAIT: begin
                state_d = OSC_XFER_EN;
            end
            OSC_XFER_EN: begin
                if (i_rem_osc_transfer_en) begin
                    state_d = OSC_ALIVE;                   // Far side saw our clock
                end
            end
            OSC_ALIVE: begin
                state_d = OSC_ALIVE;
            end
            default: begin
                state_d = OSC_WAIT;
            end
        endcase
        if (!i_config_done) begin
            state_d = OSC_WAIT;                            // Config withdrawn
        end
    end

    // ========================================
    // State and output flops
    // ========================================
    always_ff @(posedge osc_clk or negedge ms_reset_n_sync) begin
        if (!ms_reset_n_sync) begin
            state_q              <= OSC_WAIT;
            o_osc_transfer_en    <= 1'b0;
            o_osc_transfer_alive <= 1'b0;
        end else begin
            state_q              <= state_d;
            o_osc_transfer_en    <= state_q inside {OSC_XFER_EN, OSC_ALIVE};
            o_osc_transfer_alive <= (state_q == OSC_ALIVE);
        end
    end

    // Alive only rises out of enable
    a_alive_after_en: assert property (
        @(posedge osc_clk) disable iff (!ms_reset_n_sync)
        $rose(o_osc_transfer_alive) |-> $past(o_osc_transfer_en) && o_osc_transfer_en
    );

endmodule

// ==== design/aib_bit_sync.sv ====
`timescale 1ns/1ps

module aib_bit_sync (
    input  logic                            osc_clk,
    input  logic                            ms_reset_n_sync,
    input  logic [aib_cal_pkg::SYNC_W-1:0]  i_async,
    output logic [aib_cal_pkg::SYNC_W-1:0]  o_sync
);

    import aib_cal_pkg::*;

    // One row per stage, one column per status bit
    logic [SYNC_W-1:0] sync_q [SYNC_STAGES];

    // ========================================
    // Flop chains
    // ========================================
    always_ff @(posedge osc_clk or negedge ms_reset_n_sync) begin
        if (!ms_reset_n_sync) begin
            for (int i = 0; i < SYNC_STAGES; i++) begin
                sync_q[i] <= '0;
            end
        end else begin
            sync_q[0] <= i_async;                          // May go metastable
            for (int i = 1; i < SYNC_STAGES; i++) begin
                sync_q[i] <= sync_q[i-1];
            end
        end
    end

    assign o_sync = sync_q[SYNC_STAGES-1];                 // Settled levels

endmodule

// ==== design/aib_cal_pkg.sv ====
package aib_cal_pkg;

    // ========================================
    // Status synchronizer bank
    // ========================================
    localparam int SYNC_STAGES = 2;
    localparam int SYNC_W      = 11;

    // Bit positions in the synchronized status vector
    localparam int SYNC_CONFIG_DONE     = 0;
    localparam int SYNC_REM_OSC_EN      = 1;
    localparam int SYNC_REM_TX_REQ      = 2;
    localparam int SYNC_LOC_RX_REQ      = 3;
    localparam int SYNC_LOC_RX_LOCK     = 4;
    localparam int SYNC_REM_TX_CAL_DONE = 5;
    localparam int SYNC_REM_RX_REQ      = 6;
    localparam int SYNC_LOC_TX_REQ      = 7;
    localparam int SYNC_LOC_TX_CAL_DONE = 8;
    localparam int SYNC_REM_RX_LOCK     = 9;
    localparam int SYNC_REM_RX_XFER_EN  = 10;

    // ========================================
    // Oscillator hand-off FSM
    // ========================================
    localparam int OSC_STATE_W = 2;

    localparam logic [OSC_STATE_W-1:0] OSC_WAIT    = 2'd0;
    localparam logic [OSC_STATE_W-1:0] OSC_XFER_EN = 2'd1;
    localparam logic [OSC_STATE_W-1:0] OSC_ALIVE   = 2'd2;

    // ========================================
    // Calibration FSMs
    // ========================================
    localparam int CAL_STATE_W = 3;

    localparam logic [CAL_STATE_W-1:0] RXC_WAIT         = 3'd0;
    localparam logic [CAL_STATE_W-1:0] RXC_WAIT_REM_CAL = 3'd1;    // Remote TX doing DCC
    localparam logic [CAL_STATE_W-1:0] RXC_LOCK_REQ     = 3'd2;
    localparam logic [CAL_STATE_W-1:0] RXC_LOCKED       = 3'd3;
    localparam logic [CAL_STATE_W-1:0] RXC_XFER_EN      = 3'd4;

    localparam logic [CAL_STATE_W-1:0] TXC_WAIT          = 3'd0;
    localparam logic [CAL_STATE_W-1:0] TXC_CAL_REQ       = 3'd1;   // Local DCC running
    localparam logic [CAL_STATE_W-1:0] TXC_WAIT_REM_LOCK = 3'd2;
    localparam logic [CAL_STATE_W-1:0] TXC_WAIT_REM_XFER = 3'd3;
    localparam logic [CAL_STATE_W-1:0] TXC_XFER_EN       = 3'd4;

endpackage
